// ==== verilog/synth_pkg.sv ====
// Synth voice package with shared widths, note request struct and voice states
`default_nettype none

package synth_pkg;

    // Frequency in hertz as it comes from the keyboard side
    typedef logic [11:0] freq_t;

    // Wave period in clock cycles
    // Wide enough for the clock rate divided by 1
    typedef logic [19:0] period_t;

    // Signed audio sample
    typedef logic signed [15:0] sample_t;

    // Amplitude times count, formed in the first shaper stage
    typedef logic [35:0] product_t;

    // Note request as seen by the voice controller
    typedef struct packed {
        // Requested pitch
        freq_t freq;
        // Set while the request is a real note
        logic  valid;
    } note_req_t;

    // Voice sequencing states
    typedef enum logic [1:0] {
        // Silent, waiting for a note
        IDLE,
        // First period calculation of a note
        CALC,
        // Waveform running
        PLAY,
        // New period being calculated, old one still audible
        RETUNE
    } voice_state_t;

endpackage

`default_nettype wire

// ==== verilog/period_divider.sv ====
// Period divider, iterative restoring division of the clock rate by the note frequency
`default_nettype none

module period_divider #(
    parameter int CLK_HZ = 1000000
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  synth_pkg::freq_t freq,
    output logic             done,
    output synth_pkg::period_t quotient
);

    import synth_pkg::*;

    // Number of quotient bits, one per iteration
    localparam int STEPS = $bits(period_t);
    localparam int FW = $bits(freq_t);

    // Fixed dividend
    localparam period_t DIVIDEND = period_t'(CLK_HZ);

    logic          busy;
    logic [4:0]    step;
    // Dividend shifts out at the top, quotient bits shift in at the bottom
    period_t       quo_sh;
    freq_t         rem;
    freq_t         divisor;
    logic [FW:0]   trial;
    logic [FW:0]   diff;
    logic          fits;

    // One restoring step
    always_comb begin
        // Bring down the next dividend bit
        trial = {rem, quo_sh[STEPS-1]};
        diff = trial - {1'b0, divisor};
        fits = trial >= {1'b0, divisor};
    end

    // Sequencing, setup cycle on start then 20 iterations
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            // A new start always restarts, any old result is dropped
            if (start) begin
                busy <= 1'b1;
                step <= 5'(STEPS - 1);
            end else if (busy) begin
                step <= step - 5'd1;
                if (step == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            quo_sh <= DIVIDEND;
            rem <= '0;
            divisor <= freq;
        end else if (busy) begin
            // Remainder stays below the divisor, so the top bit drops
            rem <= fits ? diff[FW-1:0] : trial[FW-1:0];
            quo_sh <= {quo_sh[STEPS-2:0], fits};
            // Last bit, result held until the next start
            if (step == '0) begin
                quotient <= {quo_sh[STEPS-2:0], fits};
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/phase_counter.sv ====
// Phase counter, steps through one wave period and restarts on load
`default_nettype none

module phase_counter (
    input  logic               clk,
    input  logic               reset,
    input  logic               load,
    input  logic               run,
    input  synth_pkg::period_t period,
    output synth_pkg::period_t count
);

    import synth_pkg::*;

    // Period of the waveform now playing
    period_t period_q;
    // Final count value of one period
    period_t last;

    assign last = period_q - period_t'(1);

    // Period only changes on load
    always_ff @(posedge clk) begin
        if (load) begin
            period_q <= period;
        end
    end

    // Cycle count within the period
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            // Restart at phase zero with the new period
            count <= '0;
        end else if (!run) begin
            // Parked at zero while silent, so a new note starts clean
            count <= '0;
        end else if (count >= last) begin
            // Wrap at the end of the period
            count <= '0;
        end else begin
            count <= count + period_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/wave_shaper.sv ====
// Wave shaper, two stage pipeline forming sawtooth and triangle samples from the phase
`default_nettype none

module wave_shaper #(
    parameter int AMPLITUDE = 8191
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               run,
    input  synth_pkg::period_t count,
    input  synth_pkg::period_t period,
    output synth_pkg::sample_t sig_saw,
    output synth_pkg::sample_t sig_tri
);

    import synth_pkg::*;

    localparam product_t AMP_P = product_t'(AMPLITUDE);
    localparam sample_t AMP_S = sample_t'(AMPLITUDE);
    // Triangle level shift
    localparam sample_t QUARTER = sample_t'(AMPLITUDE >> 2);

    // Period of the wave the count belongs to
    period_t  per_eff;
    // Period used on the previous cycle
    period_t  per_hold;
    // Stage 1 registers
    logic     run1;
    product_t product1;
    period_t  period1;
    logic     half1;
    // Stage 2 arithmetic
    product_t ratio;
    sample_t  offset;
    sample_t  saw_next;
    sample_t  mag;
    sample_t  tri_next;

    // A new period takes effect when the count restarts at zero
    // Until then the old wave keeps its own period
    assign per_eff = (count == '0) ? period : per_hold;

    // Stage 1 control
    always_ff @(posedge clk) begin
        if (reset) begin
            run1 <= 1'b0;
        end else begin
            run1 <= run;
        end
    end

    // Stage 1 datapath, product and half period flag
    always_ff @(posedge clk) begin
        per_hold <= per_eff;
        product1 <= AMP_P * product_t'(count);
        period1 <= per_eff;
        // Second half when twice the count reaches the period
        half1 <= {count, 1'b0} >= {1'b0, per_eff};
    end

    // Stage 2 arithmetic
    always_comb begin
        ratio = product1 / product_t'(period1);
        offset = half1 ? AMP_S : '0;
        // Sawtooth, ramps up then jumps down by the amplitude
        saw_next = sample_t'(ratio[15:0]) - offset;
        // Absolute value folds the ramp into a triangle
        mag = saw_next[15] ? -saw_next : saw_next;
        // Center on zero and scale
        tri_next = (mag - QUARTER) <<< 2;
    end

    // Stage 2 output registers
    always_ff @(posedge clk) begin
        if (reset) begin
            sig_saw <= '0;
            sig_tri <= '0;
        end else if (!run || !run1) begin
            // Silent, also while the pipeline fills after a note starts
            sig_saw <= '0;
            sig_tri <= '0;
        end else begin
            sig_saw <= saw_next;
            sig_tri <= tri_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/voice_ctrl.sv ====
// Voice controller, note FSM that runs the divider, loads the counter and gates playback
`default_nettype none

module voice_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               note_on,
    input  logic               note_off,
    input  synth_pkg::freq_t   freq,
    input  logic               div_done,
    input  synth_pkg::period_t quotient,
    output logic               div_start,
    output logic               cnt_load,
    output logic               run,
    output logic               playing,
    output synth_pkg::period_t period,
    output synth_pkg::freq_t   div_freq
);

    import synth_pkg::*;

    voice_state_t state;
    // Request on the inputs this cycle
    note_req_t    new_req;
    // Note now held by the voice
    note_req_t    cur_req;
    logic         retune;

    // Zero frequency never counts as a note
    assign new_req = '{freq: freq, valid: note_on && (freq != '0)};

    // Pitch bend while a note is held
    assign retune = cur_req.valid && (freq != '0) && (freq != cur_req.freq);

    // Divider works on the held frequency
    assign div_freq = cur_req.freq;

    // Counter and shaper run exactly while the voice is audible
    assign run = playing;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            cur_req <= '0;
            div_start <= 1'b0;
            cnt_load <= 1'b0;
            playing <= 1'b0;
        end else begin
            // Strobes last one cycle
            div_start <= 1'b0;
            cnt_load <= 1'b0;
            if (note_off) begin
                // Any division still running is simply ignored
                state <= IDLE;
                cur_req.valid <= 1'b0;
                playing <= 1'b0;
            end else begin
                case (state)
                    IDLE: begin
                        if (new_req.valid) begin
                            cur_req <= new_req;
                            div_start <= 1'b1;
                            state <= CALC;
                        end
                    end
                    CALC: begin
                        // First period ready, start sounding
                        if (div_done) begin
                            period <= quotient;
                            cnt_load <= 1'b1;
                            playing <= 1'b1;
                            state <= PLAY;
                        end
                    end
                    PLAY: begin
                        // Old period keeps playing during the calculation
                        if (retune) begin
                            cur_req.freq <= freq;
                            div_start <= 1'b1;
                            state <= RETUNE;
                        end
                    end
                    RETUNE: begin
                        if (div_done) begin
                            period <= quotient;
                            cnt_load <= 1'b1;
                            state <= PLAY;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tone_voice.sv ====
// Tone voice top, one sawtooth and triangle oscillator voice
`default_nettype none

module tone_voice #(
    parameter int CLK_HZ    = 1000000,
    parameter int AMPLITUDE = 8191
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               note_on,
    input  logic               note_off,
    input  synth_pkg::freq_t   freq,
    output synth_pkg::sample_t sig_saw,
    output synth_pkg::sample_t sig_tri,
    output logic               playing
);

    import synth_pkg::*;

    // Controller to divider
    logic    div_start;
    freq_t   div_dividend_freq;
    // Divider back to controller
    logic    div_done;
    period_t quotient;
    // Controller to counter and shaper
    logic    cnt_load;
    logic    run;
    period_t period;
    // Phase of the running wave
    period_t count;

    voice_ctrl u_voice_ctrl (
        .clk       (clk),
        .reset     (reset),
        .note_on   (note_on),
        .note_off  (note_off),
        .freq      (freq),
        .div_done  (div_done),
        .quotient  (quotient),
        .div_start (div_start),
        .cnt_load  (cnt_load),
        .run       (run),
        .playing   (playing),
        .period    (period),
        .div_freq  (div_dividend_freq)
    );

    period_divider #(.CLK_HZ(CLK_HZ)) u_period_divider (
        .clk      (clk),
        .reset    (reset),
        .start    (div_start),
        .freq     (div_dividend_freq),
        .done     (div_done),
        .quotient (quotient)
    );

    phase_counter u_phase_counter (
        .clk    (clk),
        .reset  (reset),
        .load   (cnt_load),
        .run    (run),
        .period (period),
        .count  (count)
    );

    wave_shaper #(.AMPLITUDE(AMPLITUDE)) u_wave_shaper (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .count   (count),
        .period  (period),
        .sig_saw (sig_saw),
        .sig_tri (sig_tri)
    );

endmodule

`default_nettype wire

// ==== verification/tb_tone_model.svh ====
// Tone voice reference model, wave period and sawtooth and triangle rules
`ifndef TB_TONE_MODEL_SVH
`define TB_TONE_MODEL_SVH

// Wave period in clock cycles for a note frequency
function automatic int model_period(input int clk_hz, input int f);
    return clk_hz / f;
endfunction

// Sawtooth sample for one phase count
function automatic int model_saw(input int amp, input int cnt, input int period);
    longint ramp;
    int     offset;
    ramp = longint'(amp) * longint'(cnt) / longint'(period);
    // Second half of the period sits one amplitude lower
    offset = (2 * cnt >= period) ? amp : 0;
    return int'(ramp) - offset;
endfunction

// Triangle sample derived from the sawtooth
function automatic int model_tri(input int amp, input int saw);
    int mag;
    // Fold the ramp
    mag = (saw < 0) ? -saw : saw;
    // Center on zero, then scale by four
    return (mag - amp / 4) * 4;
endfunction

`endif

// ==== verification/tb_tone_voice.sv ====
// Tone voice testbench, table driven notes checked against a reference model
`default_nettype none

module tb_tone_voice;

    timeunit 1ns;
    timeprecision 1ps;

    import synth_pkg::*;

    localparam int CLK_HZ = 1000000;
    localparam int AMPLITUDE = 8191;
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    // Silent cycles checked before the first note
    localparam int IDLE_CHECKS = 8;
    // Divider latency plus the controller edge
    localparam int RISE_LIMIT = 22;
    // Retune age at which the count restarts with the new period
    localparam int RT_RESTART = 24;
    localparam int MARGIN_CYCLES = 200;
    localparam int NUM_STEPS = 6;

    `include "tb_tone_model.svh"

    typedef enum logic [1:0] {ACT_NOTE_ON, ACT_NOTE_OFF, ACT_RETUNE} action_t;

    typedef struct packed {
        action_t act;
        freq_t   freq;
        int      hold;
    } step_t;

    // Model state seen by the shaper one or two cycles back
    typedef struct packed {
        logic act;
        int   cnt;
        int   per;
    } hist_t;

    // Action, frequency, cycles to hold
    step_t steps [NUM_STEPS] = '{
        '{ACT_NOTE_ON,  12'd440,  4700},
        '{ACT_RETUNE,   12'd1000, 2200},
        '{ACT_NOTE_OFF, 12'd1000, 20},
        '{ACT_NOTE_ON,  12'd0,    60},
        '{ACT_NOTE_ON,  12'd1000, 1100},
        '{ACT_NOTE_OFF, 12'd1000, 16}
    };

    logic    clk = 1'b0;
    logic    reset;
    logic    note_on;
    logic    note_off;
    freq_t   freq;
    sample_t sig_saw;
    sample_t sig_tri;
    logic    playing;

    int errors = 0;
    int checks = 0;

    // Reference model
    bit    m_active = 1'b0;
    bit    waiting = 1'b0;
    bit    off_pending = 1'b0;
    bit    load_next = 1'b0;
    bit    rt_pending = 1'b0;
    int    wait_cnt = 0;
    int    rt_age = 0;
    int    rt_period = 1;
    int    note_period = 1;
    int    m_count = 0;
    int    period_cnt = 1;
    hist_t h1 = '0;
    hist_t h2 = '0;

    tone_voice #(
        .CLK_HZ    (CLK_HZ),
        .AMPLITUDE (AMPLITUDE)
    ) i_dut (
        .clk      (clk),
        .reset    (reset),
        .note_on  (note_on),
        .note_off (note_off),
        .freq     (freq),
        .sig_saw  (sig_saw),
        .sig_tri  (sig_tri),
        .playing  (playing)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare(input string name, input logic signed [31:0] got,
                           input logic signed [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Advance the model to the state after the last rising edge
    task automatic model_step();
        if (off_pending) begin
            off_pending = 1'b0;
            m_active = 1'b0;
            waiting = 1'b0;
            rt_pending = 1'b0;
            load_next = 1'b0;
            m_count = 0;
        end else if (waiting) begin
            if (playing) begin
                // Count parked at zero, load restarts it at zero once more
                waiting = 1'b0;
                m_active = 1'b1;
                m_count = 0;
                load_next = 1'b1;
                period_cnt = note_period;
            end else if (wait_cnt == RISE_LIMIT) begin
                errors++;
                $display("** Error at %0t ns: playing did not rise within %0d cycles of note_on",
                         $time, RISE_LIMIT);
                waiting = 1'b0;
            end else begin
                wait_cnt++;
            end
        end else if (m_active) begin
            if (rt_pending) begin
                rt_age++;
            end
            // Old period stays in use up to the count restart
            if (rt_pending && rt_age == RT_RESTART) begin
                m_count = 0;
                period_cnt = rt_period;
                rt_pending = 1'b0;
            end else if (load_next) begin
                m_count = 0;
                load_next = 1'b0;
            end else if (m_count >= period_cnt - 1) begin
                m_count = 0;
            end else begin
                m_count++;
            end
        end
    endtask

    // One clock of checks, sampled mid cycle
    task automatic cycle_check();
        int exp_saw;
        int exp_tri;
        @(negedge clk);
        model_step();
        exp_saw = 0;
        exp_tri = 0;
        // Output needs two running cycles to fill the pipeline
        if (h1.act && h2.act) begin
            exp_saw = model_saw(AMPLITUDE, h2.cnt, h2.per);
            exp_tri = model_tri(AMPLITUDE, exp_saw);
        end
        compare("playing", 32'(playing), 32'(m_active));
        compare("sig_saw", 32'(sig_saw), exp_saw);
        compare("sig_tri", 32'(sig_tri), exp_tri);
        h2 = h1;
        h1 = '{act: m_active, cnt: m_count, per: period_cnt};
    endtask

    task automatic apply_step(input step_t s);
        case (s.act)
            ACT_NOTE_ON: begin
                note_on = 1'b1;
                freq = s.freq;
                // Zero frequency is no note
                if (!m_active && s.freq != '0) begin
                    waiting = 1'b1;
                    wait_cnt = 0;
                    note_period = model_period(CLK_HZ, int'(s.freq));
                end
            end
            ACT_NOTE_OFF: begin
                note_off = 1'b1;
                off_pending = 1'b1;
            end
            default: begin
                freq = s.freq;
                rt_pending = 1'b1;
                rt_age = 0;
                rt_period = model_period(CLK_HZ, int'(s.freq));
            end
        endcase
    endtask

    initial begin
        reset = 1'b1;
        note_on = 1'b0;
        note_off = 1'b0;
        freq = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        // Silent voice before any note
        repeat (IDLE_CHECKS) cycle_check();
        for (int i = 0; i < NUM_STEPS; i++) begin
            apply_step(steps[i]);
            for (int h = 0; h < steps[i].hold; h++) begin
                cycle_check();
                // Strobes last one cycle
                if (h == 0) begin
                    note_on = 1'b0;
                    note_off = 1'b0;
                end
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int total;
        total = RESET_CYCLES + IDLE_CHECKS + MARGIN_CYCLES;
        for (int i = 0; i < NUM_STEPS; i++) begin
            total += steps[i].hold;
        end
        #(total * CLK_PERIOD);
        $display("** Error at %0t ns: watchdog expired before the stimulus table finished", $time);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verification
verilog/synth_pkg.sv
verilog/period_divider.sv
verilog/phase_counter.sv
verilog/wave_shaper.sv
verilog/voice_ctrl.sv
verilog/tone_voice.sv
verification/tb_tone_voice.sv

// ==== run.sh ====
#!/bin/sh
# Build the tone voice testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module tb_tone_voice -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_tone_voice)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx 'PASS: all tests'; then
    exit 0
fi
exit 1
